// File: scratch_pkg.sv
// Scratchpad shared definitions

package scratch_pkg;

    // memory word and byte lanes
    localparam int DATA_W = 32;
    localparam int MASK_W = 4;

    // word address into the scratch RAM
    localparam int ADDR_W    = 8;
    localparam int RAM_WORDS = 1 << ADDR_W;

    // queue depths and the credits granted by the response receiver
    localparam int REQ_DEPTH    = 4;
    localparam int RESP_DEPTH   = 4;
    localparam int RESP_CREDITS = 2;

    // rejected-write counter width
    localparam int CNT_W = 16;

    // request as it sits in the request queue, 45 bits
    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [MASK_W-1:0] mask;
        logic [DATA_W-1:0] data;
    } req_t;

    // response as it sits in the response queue, 42 bits
    typedef struct packed {
        logic              error;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } resp_t;

endpackage

// File: dp_ram.sv
// Dual-port RAM with byte lanes

`timescale 1ns/100ps

module dp_ram #(
    parameter int DATAW   = 32,
    parameter int SIZE    = 16,
    parameter int WRENW   = 1,
    parameter bit OUT_REG = 1'b0,
    parameter logic [DATAW-1:0] INIT_VALUE = '0,
    parameter int ADDRW   = (SIZE > 1) ? $clog2(SIZE) : 1
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             read,
    input  logic             write,
    input  logic [WRENW-1:0] wren,
    input  logic [ADDRW-1:0] waddr,
    input  logic [DATAW-1:0] wdata,
    input  logic [ADDRW-1:0] raddr,
    output logic [DATAW-1:0] rdata
);

    localparam int WSELW = DATAW / WRENW;

    logic [DATAW-1:0] ram [0:SIZE-1];
    logic [DATAW-1:0] wdata_merged;

    // every word starts from the init value at time zero
    initial begin
        for (int i = 0; i < SIZE; i++) begin
            ram[i] = INIT_VALUE;
        end
    end

    // lanes not enabled keep the old contents of the word
    always_comb begin
        wdata_merged = ram[waddr];
        for (int i = 0; i < WRENW; i++) begin
            if (wren[i]) begin
                wdata_merged[i * WSELW +: WSELW] = wdata[i * WSELW +: WSELW];
            end
        end
    end

    always @(posedge clk) begin
        if (write) begin
            ram[waddr] <= wdata_merged;
        end
    end

    generate
        if (OUT_REG) begin : g_sync
            logic [ADDRW-1:0] raddr_r;

            // the address is held and the array is read after the edge,
            // so a write at the same edge shows up in the data
            always_ff @(posedge clk) begin
                if (reset) begin
                    raddr_r <= '0;
                end else if (read) begin
                    raddr_r <= raddr;
                end
            end

            assign rdata = ram[raddr_r];
        end else begin : g_async
            // combinational read sees a word written at the last edge
            assign rdata = ram[raddr];
        end
    endgenerate

endmodule

// File: credit_fifo.sv
// Credit-returning queue

`timescale 1ns/100ps

module credit_fifo #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 4
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   push,
    input  entry_t push_data,
    input  logic   pop,
    output entry_t head,
    output logic   not_empty,
    output logic   credit
);

    localparam int ENTRY_W = $bits(entry_t);
    localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int OCC_W   = $clog2(DEPTH + 1);

    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [OCC_W-1:0]   count;
    logic               do_pop;
    logic [ENTRY_W-1:0] head_bits;

    // the sender's credits keep pushes within the free space
    assign do_pop    = pop && not_empty;
    assign not_empty = (count != '0);

    // one credit goes back for every entry that leaves
    assign credit = do_pop;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    dp_ram #(
        .DATAW   (ENTRY_W),
        .SIZE    (DEPTH),
        .WRENW   (1),
        .OUT_REG (1'b0),
        .ADDRW   (PTR_W)
    ) store (
        .clk   (clk),
        .reset (reset),
        .read  (do_pop),
        .write (push),
        .wren  (1'b1),
        .waddr (wr_ptr),
        .wdata (ENTRY_W'(push_data)),
        .raddr (rd_ptr),
        .rdata (head_bits)
    );

    assign head = entry_t'(head_bits);

endmodule

// File: scratch_cfg.sv
// Scratchpad configuration registers

`timescale 1ns/100ps

module scratch_cfg
    import scratch_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              cfg_write,
    input  logic              cfg_addr,
    input  logic [DATA_W-1:0] cfg_wdata,
    input  logic              reject,
    output logic [DATA_W-1:0] cfg_rdata,
    output logic [ADDR_W-1:0] protect_limit
);

    logic [CNT_W-1:0] reject_cnt;
    logic             clear_cnt;

    assign clear_cnt = cfg_write && cfg_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            protect_limit <= '0;
        end else if (cfg_write && !cfg_addr) begin
            protect_limit <= cfg_wdata[ADDR_W-1:0];
        end
    end

    // a clear in the same cycle as a reject wins
    always_ff @(posedge clk) begin
        if (reset) begin
            reject_cnt <= '0;
        end else if (clear_cnt) begin
            reject_cnt <= '0;
        end else if (reject && (reject_cnt != '1)) begin
            reject_cnt <= reject_cnt + 1'b1;
        end
    end

    always_comb begin
        if (cfg_addr) begin
            cfg_rdata = DATA_W'(reject_cnt);
        end else begin
            cfg_rdata = DATA_W'(protect_limit);
        end
    end

endmodule

// File: scratch_engine.sv
// Scratchpad request engine

`timescale 1ns/100ps

module scratch_engine
    import scratch_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  req_t              req_head,
    input  logic              req_not_empty,
    input  logic [ADDR_W-1:0] protect_limit,
    input  logic              resp_fifo_credit,
    input  resp_t             resp_head,
    input  logic              resp_not_empty,
    input  logic              resp_credit,
    input  logic [DATA_W-1:0] ram_rdata,
    output logic              req_pop,
    output logic              reject,
    output logic              ram_read,
    output logic              ram_write,
    output logic [MASK_W-1:0] ram_wren,
    output logic [ADDR_W-1:0] ram_addr,
    output logic [DATA_W-1:0] ram_wdata,
    output logic              resp_push,
    output resp_t             resp_data,
    output logic              resp_pop,
    output logic              resp_valid,
    output logic              resp_error,
    output logic              resp_write,
    output logic [ADDR_W-1:0] resp_addr,
    output logic [DATA_W-1:0] resp_rdata
);

    localparam int SPACE_W = $clog2(RESP_DEPTH + 1);
    localparam int DN_W    = $clog2(RESP_CREDITS + 1);

    logic [SPACE_W-1:0] space;
    logic [DN_W-1:0]    dn_credits;
    logic               blocked;
    logic               send;

    logic              stage_valid;
    logic              stage_error;
    logic              stage_write;
    logic [ADDR_W-1:0] stage_addr;
    logic [DATA_W-1:0] stage_data;

    // a slot in the response queue is reserved when a request issues
    assign req_pop = req_not_empty && (space != '0);
    assign blocked = req_head.write && (req_head.addr < protect_limit);
    assign reject  = req_pop && blocked;

    assign ram_read  = req_pop && !req_head.write;
    assign ram_write = req_pop && req_head.write && !blocked;
    assign ram_wren  = req_head.mask;
    assign ram_addr  = req_head.addr;
    assign ram_wdata = req_head.data;

    always_ff @(posedge clk) begin
        if (reset) begin
            space <= SPACE_W'(RESP_DEPTH);
        end else begin
            space <= space - SPACE_W'(req_pop) + SPACE_W'(resp_fifo_credit);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= req_pop;
        end
    end

    // response fields wait one cycle for the registered RAM read
    always_ff @(posedge clk) begin
        if (req_pop) begin
            stage_error <= blocked;
            stage_write <= req_head.write;
            stage_addr  <= req_head.addr;
            stage_data  <= blocked ? '0 : req_head.data;
        end
    end

    assign resp_push       = stage_valid;
    assign resp_data.error = stage_error;
    assign resp_data.write = stage_write;
    assign resp_data.addr  = stage_addr;
    assign resp_data.data  = stage_write ? stage_data : ram_rdata;

    // downstream credits decide when the queue head may leave
    assign send = resp_not_empty && (dn_credits != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            dn_credits <= DN_W'(RESP_CREDITS);
        end else begin
            dn_credits <= dn_credits - DN_W'(send) + DN_W'(resp_credit);
        end
    end

    assign resp_pop   = send;
    assign resp_valid = send;
    assign resp_error = resp_head.error;
    assign resp_write = resp_head.write;
    assign resp_addr  = resp_head.addr;
    assign resp_rdata = resp_head.data;

endmodule

// File: scratch_top.sv
// Scratchpad subsystem top

`timescale 1ns/100ps

module scratch_top
    import scratch_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              req_valid,
    input  logic              req_write,
    input  logic [ADDR_W-1:0] req_addr,
    input  logic [MASK_W-1:0] req_mask,
    input  logic [DATA_W-1:0] req_wdata,
    output logic              req_credit,
    output logic              resp_valid,
    output logic              resp_error,
    output logic              resp_write,
    output logic [ADDR_W-1:0] resp_addr,
    output logic [DATA_W-1:0] resp_rdata,
    input  logic              resp_credit,
    input  logic              cfg_write,
    input  logic              cfg_addr,
    input  logic [DATA_W-1:0] cfg_wdata,
    output logic [DATA_W-1:0] cfg_rdata
);

    req_t              req_in;
    req_t              req_head;
    logic              req_not_empty;
    logic              req_pop;
    resp_t             resp_in;
    resp_t             resp_head;
    logic              resp_push;
    logic              resp_pop;
    logic              resp_not_empty;
    logic              resp_fifo_credit;
    logic [ADDR_W-1:0] protect_limit;
    logic              reject;
    logic              ram_read;
    logic              ram_write;
    logic [MASK_W-1:0] ram_wren;
    logic [ADDR_W-1:0] ram_addr;
    logic [DATA_W-1:0] ram_wdata;
    logic [DATA_W-1:0] ram_rdata;

    assign req_in = '{write: req_write, addr: req_addr, mask: req_mask, data: req_wdata};

    credit_fifo #(.entry_t(req_t), .DEPTH(REQ_DEPTH)) req_q (
        .clk       (clk),
        .reset     (reset),
        .push      (req_valid),
        .push_data (req_in),
        .pop       (req_pop),
        .head      (req_head),
        .not_empty (req_not_empty),
        .credit    (req_credit)
    );

    credit_fifo #(.entry_t(resp_t), .DEPTH(RESP_DEPTH)) resp_q (
        .clk       (clk),
        .reset     (reset),
        .push      (resp_push),
        .push_data (resp_in),
        .pop       (resp_pop),
        .head      (resp_head),
        .not_empty (resp_not_empty),
        .credit    (resp_fifo_credit)
    );

    scratch_engine engine (
        .clk              (clk),
        .reset            (reset),
        .req_head         (req_head),
        .req_not_empty    (req_not_empty),
        .protect_limit    (protect_limit),
        .resp_fifo_credit (resp_fifo_credit),
        .resp_head        (resp_head),
        .resp_not_empty   (resp_not_empty),
        .resp_credit      (resp_credit),
        .ram_rdata        (ram_rdata),
        .req_pop          (req_pop),
        .reject           (reject),
        .ram_read         (ram_read),
        .ram_write        (ram_write),
        .ram_wren         (ram_wren),
        .ram_addr         (ram_addr),
        .ram_wdata        (ram_wdata),
        .resp_push        (resp_push),
        .resp_data        (resp_in),
        .resp_pop         (resp_pop),
        .resp_valid       (resp_valid),
        .resp_error       (resp_error),
        .resp_write       (resp_write),
        .resp_addr        (resp_addr),
        .resp_rdata       (resp_rdata)
    );

    scratch_cfg cfg (
        .clk           (clk),
        .reset         (reset),
        .cfg_write     (cfg_write),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .reject        (reject),
        .cfg_rdata     (cfg_rdata),
        .protect_limit (protect_limit)
    );

    // one address serves both ports since the engine issues one access per cycle
    dp_ram #(
        .DATAW      (DATA_W),
        .SIZE       (RAM_WORDS),
        .WRENW      (MASK_W),
        .OUT_REG    (1'b1),
        .INIT_VALUE ('0),
        .ADDRW      (ADDR_W)
    ) scratch_ram (
        .clk   (clk),
        .reset (reset),
        .read  (ram_read),
        .write (ram_write),
        .wren  (ram_wren),
        .waddr (ram_addr),
        .wdata (ram_wdata),
        .raddr (ram_addr),
        .rdata (ram_rdata)
    );

endmodule

// File: scratch_tb_sva.sv
// Engine protocol assertions

`timescale 1ns/100ps

module scratch_tb_sva
    import scratch_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic req_pop,
    input logic resp_push,
    input logic resp_pop,
    input logic resp_valid,
    input logic resp_credit
);

    int dn_seen;
    int issued;
    int queued;

    // credits and occupancy rebuilt from the strobes alone
    always_ff @(posedge clk) begin
        if (reset) begin
            dn_seen <= RESP_CREDITS;
            issued  <= 0;
            queued  <= 0;
        end else begin
            dn_seen <= dn_seen - int'(resp_valid) + int'(resp_credit);
            issued  <= issued + int'(req_pop) - int'(resp_pop);
            queued  <= queued + int'(resp_push) - int'(resp_pop);
        end
    end

    // a response only leaves while the receiver has granted room for it
    a_valid_credit: assert property (@(posedge clk) disable iff (reset)
        resp_valid |-> (dn_seen > 0))
        else $error("resp_valid high with no downstream credit");

    // every issued request holds a response-queue slot until its response leaves
    a_issue_room: assert property (@(posedge clk) disable iff (reset)
        req_pop |-> (issued < RESP_DEPTH))
        else $error("req_pop with every response-queue slot taken");

    a_pop_queued: assert property (@(posedge clk) disable iff (reset)
        resp_pop |-> (queued > 0))
        else $error("resp_pop while the response queue holds nothing");

endmodule

bind scratch_engine scratch_tb_sva sva (
    .clk         (clk),
    .reset       (reset),
    .req_pop     (req_pop),
    .resp_push   (resp_push),
    .resp_pop    (resp_pop),
    .resp_valid  (resp_valid),
    .resp_credit (resp_credit)
);

// File: scratch_tb.sv
// Scratchpad testbench

`timescale 1ns/100ps

module scratch_tb
    import scratch_pkg::*;
();

    localparam int FIELDS      = 7;
    localparam int LINE_MAX    = 64;
    localparam int KIND_CFG_WR = 1;
    localparam int KIND_REQ    = 2;
    localparam int KIND_CFG_RD = 3;
    localparam int KIND_END    = 15;

    logic              clk = 1'b0;
    logic              reset;
    logic              req_valid;
    logic              req_write;
    logic [ADDR_W-1:0] req_addr;
    logic [MASK_W-1:0] req_mask;
    logic [DATA_W-1:0] req_wdata;
    logic              req_credit;
    logic              resp_valid;
    logic              resp_error;
    logic              resp_write;
    logic [ADDR_W-1:0] resp_addr;
    logic [DATA_W-1:0] resp_rdata;
    logic              resp_credit;
    logic              cfg_write;
    logic              cfg_addr;
    logic [DATA_W-1:0] cfg_wdata;
    logic [DATA_W-1:0] cfg_rdata;

    logic [31:0]       tests [0:FIELDS*LINE_MAX-1];
    logic [DATA_W-1:0] model_ram [0:RAM_WORDS-1];
    logic [ADDR_W-1:0] model_limit;
    int                model_rejects;
    logic [41:0]       exp_q [$];
    string             name_q [$];
    int                credits;
    int                owed;
    int                gap;
    int                cycle;
    int                cycle_limit;
    int                num_lines;

    always #4 clk = ~clk;

    scratch_top dut (.*);

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // one falling edge: watch the outputs, then release the one-cycle strobes
    task automatic tick();
        logic [41:0] got;
        string       name;
        @(negedge clk);
        cycle++;
        if (cycle > cycle_limit) begin
            $display("run timed out after %0d cycles without all responses", cycle);
            $display("Test failed");
            $fatal(1, "timeout");
        end
        if (resp_valid) begin
            if (exp_q.size() == 0) begin
                $display("response for address %h came with no request outstanding", resp_addr);
                $display("Test failed");
                $fatal(1, "unexpected response");
            end
            got  = {resp_error, resp_write, resp_addr, resp_rdata};
            name = name_q.pop_front();
            check(name, 64'(exp_q.pop_front()), 64'(got));
            owed++;
        end
        if (req_credit) begin
            credits++;
            check("request credit bound", 64'(1), 64'(credits <= REQ_DEPTH));
        end
        req_valid   = 1'b0;
        cfg_write   = 1'b0;
        resp_credit = 1'b0;
        // the receiver hands back each credit after a random pause
        if (owed > 0) begin
            if (gap == 0) begin
                resp_credit = 1'b1;
                owed--;
                gap = $urandom_range(0, 5);
            end else begin
                gap--;
            end
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            tick();
        end
    endtask

    task automatic send_request(input int line, input int base);
        logic              wr;
        logic [ADDR_W-1:0] addr;
        logic [MASK_W-1:0] mask;
        logic [DATA_W-1:0] wdata;
        logic [DATA_W-1:0] word;
        logic [DATA_W-1:0] model_data;
        logic              model_err;
        wr         = tests[base+1][0];
        addr       = tests[base+2][ADDR_W-1:0];
        mask       = tests[base+3][MASK_W-1:0];
        wdata      = tests[base+4];
        model_err  = 1'b0;
        model_data = model_ram[addr];
        if (wr && (addr < model_limit)) begin
            model_err  = 1'b1;
            model_data = '0;
            model_rejects++;
        end else if (wr) begin
            word = model_ram[addr];
            for (int i = 0; i < MASK_W; i++) begin
                if (mask[i]) begin
                    word[i*8 +: 8] = wdata[i*8 +: 8];
                end
            end
            model_ram[addr] = word;
            model_data      = wdata;
        end
        check($sformatf("line %0d model", line), 64'({tests[base+5][0], tests[base+6]}),
              64'({model_err, model_data}));
        exp_q.push_back({tests[base+5][0], wr, addr, tests[base+6]});
        name_q.push_back($sformatf("line %0d", line));
        tick();
        while (credits == 0) begin
            tick();
        end
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = addr;
        req_mask  = mask;
        req_wdata = wdata;
        credits--;
    endtask

    task automatic config_write(input int base);
        drain();
        tick();
        cfg_write = 1'b1;
        cfg_addr  = tests[base+1][0];
        cfg_wdata = tests[base+4];
        if (cfg_addr) begin
            model_rejects = 0;
        end else begin
            model_limit = cfg_wdata[ADDR_W-1:0];
        end
    endtask

    task automatic config_read(input int line, input int base);
        logic [DATA_W-1:0] model_val;
        drain();
        tick();
        cfg_addr  = tests[base+1][0];
        model_val = cfg_addr ? DATA_W'(model_rejects) : DATA_W'(model_limit);
        check($sformatf("line %0d model", line), 64'(tests[base+6]), 64'(model_val));
        tick();
        check($sformatf("line %0d", line), 64'(tests[base+6]), 64'(cfg_rdata));
    endtask

    initial begin
        int base;
        req_valid     = 1'b0;
        req_write     = 1'b0;
        req_addr      = '0;
        req_mask      = '0;
        req_wdata     = '0;
        resp_credit   = 1'b0;
        cfg_write     = 1'b0;
        cfg_addr      = 1'b0;
        cfg_wdata     = '0;
        reset         = 1'b1;
        credits       = REQ_DEPTH;
        owed          = 0;
        gap           = 0;
        cycle         = 0;
        model_limit   = '0;
        model_rejects = 0;
        void'($urandom(57438));
        for (int i = 0; i < RAM_WORDS; i++) begin
            model_ram[i] = '0;
        end
        $readmemh("scratch_tests.mem", tests);
        num_lines = 0;
        while (num_lines < LINE_MAX && tests[num_lines*FIELDS][3:0] !== 4'(KIND_END)) begin
            num_lines++;
        end
        if (num_lines == LINE_MAX) begin
            $display("the test file has no end line");
            $display("Test failed");
            $fatal(1, "bad test file");
        end
        cycle_limit = 40 * (num_lines + 1) + 100;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        for (int line = 0; line < num_lines; line++) begin
            base = line * FIELDS;
            case (int'(tests[base][3:0]))
                KIND_CFG_WR: config_write(base);
                KIND_REQ:    send_request(line, base);
                KIND_CFG_RD: config_read(line, base);
                default: begin
                    $display("line %0d of the test file has an unknown kind", line);
                    $display("Test failed");
                    $fatal(1, "bad test file");
                end
            endcase
        end
        drain();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: scratch_top.f
scratch_pkg.sv
dp_ram.sv
credit_fifo.sv
scratch_cfg.sv
scratch_engine.sv
scratch_top.sv
scratch_tb_sva.sv
scratch_tb.sv

// File: run.sh
#!/bin/sh
# Verilator build and run of the scratchpad testbench; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module scratch_tb \
    -f scratch_top.f -o scratch_sim &&
    ./obj_dir/scratch_sim 2>&1 | tee sim.log
grep -q "Test completed successfully" sim.log && echo "PASS" || {
    echo "FAIL"
    exit 1
}

// File: scratch_tests.mem
// kind wr addr mask data exp_err exp_data
// kind 1 config write, 2 request, 3 config read, f end; wr selects the register for config
2 0 05 0 00000000 0 00000000
2 0 ff 0 00000000 0 00000000
2 1 10 f 12345678 0 12345678
2 0 10 0 00000000 0 12345678
2 1 11 f aabbccdd 0 aabbccdd
2 1 11 5 11223344 0 11223344
2 0 11 0 00000000 0 aa22cc44
1 0 00 0 00000020 0 00000000
3 0 00 0 00000000 0 00000020
2 1 10 f deadbeef 1 00000000
2 0 10 0 00000000 0 12345678
2 1 1f 3 cafef00d 1 00000000
2 1 20 f 0badf00d 0 0badf00d
3 1 00 0 00000000 0 00000002
1 1 00 0 00000000 0 00000000
3 1 00 0 00000000 0 00000000
1 0 00 0 00000000 0 00000000
2 1 40 f 01010101 0 01010101
2 1 41 f 02020202 0 02020202
2 1 42 c 03030303 0 03030303
2 1 43 f 04040404 0 04040404
2 0 40 0 00000000 0 01010101
2 0 41 0 00000000 0 02020202
2 0 42 0 00000000 0 03030000
2 0 43 0 00000000 0 04040404
2 0 20 0 00000000 0 0badf00d
2 0 11 0 00000000 0 aa22cc44
2 0 7e 0 00000000 0 00000000
f 0 00 0 00000000 0 00000000
